//--- mesh_pkg.sv
// mesh network package with geometry, opcodes, packet layout and router port numbering

package mesh_pkg;

  // grid geometry, row 0 is the IO row
  localparam int mesh_x_lp = 2;
  localparam int mesh_y_lp = 3;

  localparam int x_cord_width_lp = 1;
  localparam int y_cord_width_lp = 2;

  // scratchpad and payload widths
  localparam int addr_width_lp = 4;
  localparam int data_width_lp = 32;
  localparam int mem_words_lp  = 1 << addr_width_lp;

  // registers between rst_i and the routers and tiles
  localparam int reset_depth_lp = 3;

  // router port numbering
  localparam int dir_p = 0;
  localparam int dir_w = 1;
  localparam int dir_e = 2;
  localparam int dir_n = 3;
  localparam int dir_s = 4;

  localparam int num_dirs_lp  = 5;
  localparam int dir_width_lp = 3;

  typedef enum logic [1:0] {
    op_store = 2'd0,
    op_load  = 2'd1,
    op_reply = 2'd2
  } mesh_op_e;

  // one flit carries the whole request or reply
  typedef struct packed {
    logic [x_cord_width_lp-1:0] dest_x;
    logic [y_cord_width_lp-1:0] dest_y;
    logic [x_cord_width_lp-1:0] src_x;
    logic [y_cord_width_lp-1:0] src_y;
    mesh_op_e                   op;
    logic [addr_width_lp-1:0]   addr;
    logic [data_width_lp-1:0]   data;
  } mesh_packet_s;

endpackage

//--- mesh_router.sv
// five-port mesh router with one-entry input buffers, XY routing and round-robin outputs
`timescale 1ns/1ps

module mesh_router
  import mesh_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [x_cord_width_lp-1:0]     my_x_i,
  input  logic [y_cord_width_lp-1:0]     my_y_i,
  input  logic [num_dirs_lp-1:0]         link_valid_i,
  input  mesh_packet_s [num_dirs_lp-1:0] link_packet_i,
  output logic [num_dirs_lp-1:0]         link_ready_o,
  output logic [num_dirs_lp-1:0]         link_valid_o,
  output mesh_packet_s [num_dirs_lp-1:0] link_packet_o,
  input  logic [num_dirs_lp-1:0]         link_ready_i
);

  // input buffers, one packet per port
  logic [num_dirs_lp-1:0]         buf_valid_r;
  mesh_packet_s [num_dirs_lp-1:0] buf_packet_r;

  // low for the first cycle out of reset so nothing is taken early
  logic live_r;

  logic [num_dirs_lp-1:0][dir_width_lp-1:0] route;
  // request matrix indexed [output][input]
  logic [num_dirs_lp-1:0][num_dirs_lp-1:0]  req;

  logic [num_dirs_lp-1:0][dir_width_lp-1:0] rr_ptr_r;
  logic [num_dirs_lp-1:0]                   lock_r;
  logic [num_dirs_lp-1:0][dir_width_lp-1:0] lock_sel_r;
  logic [num_dirs_lp-1:0][dir_width_lp-1:0] sel;
  logic [num_dirs_lp-1:0]                   xfer_out;
  logic [num_dirs_lp-1:0]                   deq;
  logic [num_dirs_lp-1:0]                   enq;

  // X first, then Y; row numbers grow toward the south
  always_comb
  begin
    for (int i = 0; i < num_dirs_lp; i++)
    begin
      if (buf_packet_r[i].dest_x > my_x_i)
        route[i] = dir_width_lp'(dir_e);
      else if (buf_packet_r[i].dest_x < my_x_i)
        route[i] = dir_width_lp'(dir_w);
      else if (buf_packet_r[i].dest_y > my_y_i)
        route[i] = dir_width_lp'(dir_s);
      else if (buf_packet_r[i].dest_y < my_y_i)
        route[i] = dir_width_lp'(dir_n);
      else
        route[i] = dir_width_lp'(dir_p);
    end
  end

  always_comb
  begin
    for (int o = 0; o < num_dirs_lp; o++)
    begin
      for (int i = 0; i < num_dirs_lp; i++)
      begin
        req[o][i] = buf_valid_r[i] && (route[i] == dir_width_lp'(o));
      end
    end
  end

  // round-robin search from the pointer; a stalled output keeps its earlier pick
  always_comb
  begin : arb
    int   idx;
    logic found;
    for (int o = 0; o < num_dirs_lp; o++)
    begin
      sel[o] = rr_ptr_r[o];
      found  = 1'b0;
      for (int k = 0; k < num_dirs_lp; k++)
      begin
        idx = (int'(rr_ptr_r[o]) + k) % num_dirs_lp;
        if (!found && req[o][idx])
        begin
          sel[o] = dir_width_lp'(idx);
          found  = 1'b1;
        end
      end
      if (lock_r[o])
        sel[o] = lock_sel_r[o];
      link_valid_o[o]  = |req[o];
      link_packet_o[o] = buf_packet_r[sel[o]];
      xfer_out[o]      = link_valid_o[o] && link_ready_i[o];
    end
  end

  // a buffer frees up on the edge its packet leaves
  always_comb
  begin
    deq = '0;
    for (int o = 0; o < num_dirs_lp; o++)
    begin
      if (xfer_out[o])
        deq[sel[o]] = 1'b1;
    end
    for (int i = 0; i < num_dirs_lp; i++)
    begin
      link_ready_o[i] = live_r && (!buf_valid_r[i] || deq[i]);
      enq[i]          = link_valid_i[i] && link_ready_o[i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      live_r      <= 1'b0;
      buf_valid_r <= '0;
      rr_ptr_r    <= '0;
      lock_r      <= '0;
      lock_sel_r  <= '0;
    end
    else
    begin
      live_r <= 1'b1;
      for (int i = 0; i < num_dirs_lp; i++)
      begin
        if (enq[i])
          buf_valid_r[i] <= 1'b1;
        else if (deq[i])
          buf_valid_r[i] <= 1'b0;
      end
      for (int o = 0; o < num_dirs_lp; o++)
      begin
        // pointer moves one past the winner
        if (xfer_out[o])
          rr_ptr_r[o] <= (sel[o] == dir_width_lp'(num_dirs_lp - 1)) ? '0 : sel[o] + 1'b1;
        lock_r[o] <= link_valid_o[o] && !link_ready_i[o];
        if (link_valid_o[o] && !link_ready_i[o])
          lock_sel_r[o] <= sel[o];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < num_dirs_lp; i++)
    begin
      if (enq[i])
        buf_packet_r[i] <= link_packet_i[i];
    end
  end

endmodule

//--- mesh_tile_mem.sv
// tile endpoint with a scratchpad that serves stores and answers loads with reply packets
`timescale 1ns/1ps

module mesh_tile_mem
  import mesh_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [x_cord_width_lp-1:0] my_x_i,
  input  logic [y_cord_width_lp-1:0] my_y_i,
  input  logic                       req_valid_i,
  input  mesh_packet_s               req_packet_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output mesh_packet_s               rsp_packet_o,
  input  logic                       rsp_ready_i
);

  logic [mem_words_lp-1:0][data_width_lp-1:0] mem_r;

  logic         rsp_valid_r;
  mesh_packet_s rsp_packet_r;
  logic         req_fire;
  logic         store_fire;
  logic         load_fire;

  // loads wait for an empty reply register, stores never stall
  assign req_ready_o = !rsp_valid_r || (req_packet_i.op != op_load);
  assign req_fire    = req_valid_i && req_ready_o;
  assign store_fire  = req_fire && (req_packet_i.op == op_store);
  assign load_fire   = req_fire && (req_packet_i.op == op_load);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      mem_r <= '0;
    else if (store_fire)
      mem_r[req_packet_i.addr] <= req_packet_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      rsp_valid_r <= 1'b0;
    else if (load_fire)
      rsp_valid_r <= 1'b1;
    else if (rsp_ready_i)
      rsp_valid_r <= 1'b0;
  end

  // reply goes back to whoever issued the load
  always_ff @(posedge clk_i)
  begin
    if (load_fire)
    begin
      rsp_packet_r.dest_x <= req_packet_i.src_x;
      rsp_packet_r.dest_y <= req_packet_i.src_y;
      rsp_packet_r.src_x  <= my_x_i;
      rsp_packet_r.src_y  <= my_y_i;
      rsp_packet_r.op     <= op_reply;
      rsp_packet_r.addr   <= req_packet_i.addr;
      rsp_packet_r.data   <= mem_r[req_packet_i.addr];
    end
  end

  assign rsp_valid_o  = rsp_valid_r;
  assign rsp_packet_o = rsp_packet_r;

endmodule

//--- mesh_array.sv
// mesh array top with reset pipeline, IO-row routers, tile routers and endpoints
`timescale 1ns/1ps

module mesh_array
  import mesh_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [mesh_x_lp-1:0]         io_valid_i,
  input  mesh_packet_s [mesh_x_lp-1:0] io_packet_i,
  output logic [mesh_x_lp-1:0]         io_ready_o,
  output logic [mesh_x_lp-1:0]         io_valid_o,
  output mesh_packet_s [mesh_x_lp-1:0] io_packet_o,
  input  logic [mesh_x_lp-1:0]         io_ready_i
);

  logic [reset_depth_lp-1:0] rst_pipe_r;
  logic                      rst_core;

  // in_* are router inputs, out_* are router outputs, indexed [row][col][dir]
  logic [mesh_y_lp-1:0][mesh_x_lp-1:0][num_dirs_lp-1:0]         in_valid;
  mesh_packet_s [mesh_y_lp-1:0][mesh_x_lp-1:0][num_dirs_lp-1:0] in_packet;
  logic [mesh_y_lp-1:0][mesh_x_lp-1:0][num_dirs_lp-1:0]         in_ready;
  logic [mesh_y_lp-1:0][mesh_x_lp-1:0][num_dirs_lp-1:0]         out_valid;
  mesh_packet_s [mesh_y_lp-1:0][mesh_x_lp-1:0][num_dirs_lp-1:0] out_packet;
  logic [mesh_y_lp-1:0][mesh_x_lp-1:0][num_dirs_lp-1:0]         out_ready;

  always_ff @(posedge clk_i)
  begin
    rst_pipe_r <= {rst_pipe_r[reset_depth_lp-2:0], rst_i};
  end

  assign rst_core = rst_pipe_r[reset_depth_lp-1];

  for (genvar r = 0; r < mesh_y_lp; r++)
  begin : g_row
    for (genvar c = 0; c < mesh_x_lp; c++)
    begin : g_col
      mesh_router i_router (
        .clk_i         (clk_i),
        .rst_i         (rst_core),
        .my_x_i        (x_cord_width_lp'(c)),
        .my_y_i        (y_cord_width_lp'(r)),
        .link_valid_i  (in_valid[r][c]),
        .link_packet_i (in_packet[r][c]),
        .link_ready_o  (in_ready[r][c]),
        .link_valid_o  (out_valid[r][c]),
        .link_packet_o (out_packet[r][c]),
        .link_ready_i  (out_ready[r][c])
      );

      // west and east links, outer edges tied off
      if (c == 0)
      begin : g_w_edge
        assign in_valid[r][c][dir_w]  = 1'b0;
        assign in_packet[r][c][dir_w] = '0;
        assign out_ready[r][c][dir_w] = 1'b1;
      end
      else
      begin : g_w_link
        assign in_valid[r][c][dir_w]  = out_valid[r][c-1][dir_e];
        assign in_packet[r][c][dir_w] = out_packet[r][c-1][dir_e];
        assign out_ready[r][c][dir_w] = in_ready[r][c-1][dir_e];
      end

      if (c == mesh_x_lp - 1)
      begin : g_e_edge
        assign in_valid[r][c][dir_e]  = 1'b0;
        assign in_packet[r][c][dir_e] = '0;
        assign out_ready[r][c][dir_e] = 1'b1;
      end
      else
      begin : g_e_link
        assign in_valid[r][c][dir_e]  = out_valid[r][c+1][dir_w];
        assign in_packet[r][c][dir_e] = out_packet[r][c+1][dir_w];
        assign out_ready[r][c][dir_e] = in_ready[r][c+1][dir_w];
      end

      // north and south links
      if (r == 0)
      begin : g_n_edge
        assign in_valid[r][c][dir_n]  = 1'b0;
        assign in_packet[r][c][dir_n] = '0;
        assign out_ready[r][c][dir_n] = 1'b1;
      end
      else
      begin : g_n_link
        assign in_valid[r][c][dir_n]  = out_valid[r-1][c][dir_s];
        assign in_packet[r][c][dir_n] = out_packet[r-1][c][dir_s];
        assign out_ready[r][c][dir_n] = in_ready[r-1][c][dir_s];
      end

      if (r == mesh_y_lp - 1)
      begin : g_s_edge
        assign in_valid[r][c][dir_s]  = 1'b0;
        assign in_packet[r][c][dir_s] = '0;
        assign out_ready[r][c][dir_s] = 1'b1;
      end
      else
      begin : g_s_link
        assign in_valid[r][c][dir_s]  = out_valid[r+1][c][dir_n];
        assign in_packet[r][c][dir_s] = out_packet[r+1][c][dir_n];
        assign out_ready[r][c][dir_s] = in_ready[r+1][c][dir_n];
      end

      // P port goes to the chip IO on row 0, to the endpoint elsewhere
      if (r == 0)
      begin : g_io
        assign in_valid[r][c][dir_p]  = io_valid_i[c];
        assign in_packet[r][c][dir_p] = io_packet_i[c];
        assign io_ready_o[c]          = in_ready[r][c][dir_p];
        assign io_valid_o[c]          = out_valid[r][c][dir_p];
        assign io_packet_o[c]         = out_packet[r][c][dir_p];
        assign out_ready[r][c][dir_p] = io_ready_i[c];
      end
      else
      begin : g_tile
        mesh_tile_mem i_mem (
          .clk_i        (clk_i),
          .rst_i        (rst_core),
          .my_x_i       (x_cord_width_lp'(c)),
          .my_y_i       (y_cord_width_lp'(r)),
          .req_valid_i  (out_valid[r][c][dir_p]),
          .req_packet_i (out_packet[r][c][dir_p]),
          .req_ready_o  (out_ready[r][c][dir_p]),
          .rsp_valid_o  (in_valid[r][c][dir_p]),
          .rsp_packet_o (in_packet[r][c][dir_p]),
          .rsp_ready_i  (in_ready[r][c][dir_p])
        );
      end
    end
  end

endmodule

//--- mesh_checker.sv
// mesh array scoreboard that mirrors accepted stores and checks every load reply
`timescale 1ns/1ps

module mesh_checker
  import mesh_pkg::*;
(
  input  logic                         clk_i,
  input  logic [mesh_x_lp-1:0]         req_valid_i,
  input  mesh_packet_s [mesh_x_lp-1:0] req_packet_i,
  input  logic [mesh_x_lp-1:0]         req_ready_i,
  input  logic [mesh_x_lp-1:0]         rsp_valid_i,
  input  mesh_packet_s [mesh_x_lp-1:0] rsp_packet_i,
  input  logic [mesh_x_lp-1:0]         rsp_ready_i,
  output int                           error_count_o,
  output int                           reply_count_o
);

  // reference scratchpads indexed [x][y][addr]
  logic [data_width_lp-1:0] ref_mem [mesh_x_lp][mesh_y_lp][mem_words_lp];

  // loads still waiting for a reply, indexed [col][x][y][addr]
  int outstanding [mesh_x_lp][mesh_x_lp][mesh_y_lp][mem_words_lp];

  mesh_packet_s             pkt;
  logic [data_width_lp-1:0] expected;

  initial
  begin
    error_count_o = 0;
    reply_count_o = 0;
    for (int x = 0; x < mesh_x_lp; x++)
      for (int y = 0; y < mesh_y_lp; y++)
        for (int a = 0; a < mem_words_lp; a++)
          ref_mem[x][y][a] = '0;
  end

  // links only change on rising edges, so a handshake seen here completes on the next one
  always @(negedge clk_i)
  begin
    for (int c = 0; c < mesh_x_lp; c++)
    begin
      if (req_valid_i[c] === 1'b1 && req_ready_i[c] === 1'b1)
      begin
        pkt = req_packet_i[c];
        if (pkt.op == op_store)
          ref_mem[pkt.dest_x][pkt.dest_y][pkt.addr] = pkt.data;
        else if (pkt.op == op_load)
          outstanding[c][pkt.dest_x][pkt.dest_y][pkt.addr] =
            outstanding[c][pkt.dest_x][pkt.dest_y][pkt.addr] + 1;
      end
      if (rsp_valid_i[c] === 1'b1 && rsp_ready_i[c] === 1'b1)
      begin
        pkt           = rsp_packet_i[c];
        reply_count_o = reply_count_o + 1;
        if (pkt.op !== op_reply)
        begin
          $display("ERROR io_packet_o[%0d].op expected %h actual %h", c, op_reply, pkt.op);
          error_count_o = error_count_o + 1;
        end
        if (pkt.dest_x !== x_cord_width_lp'(c))
        begin
          $display("ERROR io_packet_o[%0d].dest_x expected %h actual %h", c,
                   x_cord_width_lp'(c), pkt.dest_x);
          error_count_o = error_count_o + 1;
        end
        if (pkt.dest_y !== y_cord_width_lp'(0))
        begin
          $display("ERROR io_packet_o[%0d].dest_y expected %h actual %h", c,
                   y_cord_width_lp'(0), pkt.dest_y);
          error_count_o = error_count_o + 1;
        end
        if (outstanding[c][pkt.src_x][pkt.src_y][pkt.addr] > 0)
        begin
          outstanding[c][pkt.src_x][pkt.src_y][pkt.addr] =
            outstanding[c][pkt.src_x][pkt.src_y][pkt.addr] - 1;
        end
        else
        begin
          $display("reply on column %0d from tile (%0d, %0d) address %0h has no load waiting",
                   c, pkt.src_x, pkt.src_y, pkt.addr);
          error_count_o = error_count_o + 1;
        end
        expected = ref_mem[pkt.src_x][pkt.src_y][pkt.addr];
        if (pkt.data !== expected)
        begin
          $display("ERROR io_packet_o[%0d].data expected %h actual %h", c, expected, pkt.data);
          error_count_o = error_count_o + 1;
        end
      end
    end
  end

endmodule

//--- tb_mesh_array.sv
// mesh array testbench that replays the test data on both IO columns under random back-pressure
`timescale 1ns/1ps

module tb_mesh_array
  import mesh_pkg::*;
;

  logic                         clk_i;
  logic                         rst_i;
  logic [mesh_x_lp-1:0]         io_valid_i;
  mesh_packet_s [mesh_x_lp-1:0] io_packet_i;
  logic [mesh_x_lp-1:0]         io_ready_o;
  logic [mesh_x_lp-1:0]         io_valid_o;
  mesh_packet_s [mesh_x_lp-1:0] io_packet_o;
  logic [mesh_x_lp-1:0]         io_ready_i;

  // header words first, then six words per stimulus line
  logic [31:0] td_words [0:255];
  int          num_lines;
  int          expected_replies;
  int          check_errors;
  int          reply_count;
  int          run_errors;
  int          cycle_count;
  int          cycle_limit;

  logic [31:0]          lfsr_state;
  logic [mesh_x_lp-1:0] ready_bits;

  mesh_array i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .io_valid_i  (io_valid_i),
    .io_packet_i (io_packet_i),
    .io_ready_o  (io_ready_o),
    .io_valid_o  (io_valid_o),
    .io_packet_o (io_packet_o),
    .io_ready_i  (io_ready_i)
  );

  mesh_checker i_checker (
    .clk_i         (clk_i),
    .req_valid_i   (io_valid_i),
    .req_packet_i  (io_packet_i),
    .req_ready_i   (io_ready_o),
    .rsp_valid_i   (io_valid_o),
    .rsp_packet_i  (io_packet_o),
    .rsp_ready_i   (io_ready_i),
    .error_count_o (check_errors),
    .reply_count_o (reply_count)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
      next = next ^ 32'h80200003;
    return next;
  endfunction

  // one LFSR step per ready bit per cycle
  always @(posedge clk_i)
  begin
    for (int c = 0; c < mesh_x_lp; c++)
    begin
      lfsr_state    = lfsr_next(lfsr_state);
      ready_bits[c] = lfsr_state[0];
    end
    io_ready_i <= ready_bits;
  end

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
  end

  task automatic finish_run;
    $display("errors: checker %0d, run %0d", check_errors, run_errors);
    if (check_errors == 0 && run_errors == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // walks the test data and sends the lines that belong to one IO column
  task automatic drive_column(input int col);
    mesh_packet_s pkt;
    int           base;
    int           i;
    for (i = 0; i < num_lines; i++)
    begin
      base = 2 + 6 * i;
      if (td_words[base] == col)
      begin
        pkt.dest_x = x_cord_width_lp'(td_words[base+2]);
        pkt.dest_y = y_cord_width_lp'(td_words[base+3]);
        pkt.src_x  = x_cord_width_lp'(col);
        pkt.src_y  = '0;
        pkt.op     = mesh_op_e'(td_words[base+1][1:0]);
        pkt.addr   = addr_width_lp'(td_words[base+4]);
        pkt.data   = td_words[base+5];
        @(posedge clk_i);
        io_valid_i[col]  <= 1'b1;
        io_packet_i[col] <= pkt;
        @(negedge clk_i);
        while (io_ready_o[col] !== 1'b1)
          @(negedge clk_i);
        @(posedge clk_i);
        io_valid_i[col] <= 1'b0;
      end
    end
  endtask

  initial
  begin
    rst_i       = 1'b1;
    io_valid_i  = '0;
    io_packet_i = '0;
    io_ready_i  = '0;
    lfsr_state  = 32'hc30f4f8b;
    cycle_count = 0;
    cycle_limit = 0;
    run_errors  = 0;
    $readmemh("mesh_testdata.txt", td_words);
    if (td_words[0] === 'x || td_words[1] === 'x)
    begin
      $display("the test data file could not be read");
      run_errors = 1;
      finish_run();
    end
    else
    begin
      num_lines        = td_words[0];
      expected_replies = td_words[1];
      cycle_limit      = 40 * num_lines + 200;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b0;
      fork
        drive_column(0);
        drive_column(1);
      join
      while (reply_count < expected_replies)
        @(posedge clk_i);
      // extra cycles so a duplicated reply still gets counted
      repeat (50) @(posedge clk_i);
      if (reply_count != expected_replies)
      begin
        $display("wrong number of replies: expected %0d, received %0d",
                 expected_replies, reply_count);
        run_errors = run_errors + 1;
      end
      finish_run();
    end
  end

  initial
  begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit)
      @(posedge clk_i);
    $display("the run did not finish within %0d cycles", cycle_limit);
    run_errors = run_errors + 1;
    finish_run();
  end

endmodule

//--- mesh_testdata.txt
// header: number of stimulus lines, expected reply count
// columns: io column, opcode (0 store, 1 load), dest x, dest y, address, store data
18 0f
// loads before any store read the reset value
0 1 0 1 5 00000000
1 1 1 2 7 00000000
// store then load within the issuing column
0 0 0 1 0 deadbeef
0 1 0 1 0 00000000
0 0 0 2 3 12345678
0 1 0 2 3 00000000
1 0 1 1 2 cafef00d
1 1 1 1 2 00000000
// traffic to the other column turns X then Y
0 0 1 2 1 a5a5a5a5
0 1 1 2 1 00000000
1 0 0 1 4 0badcafe
1 1 0 1 4 00000000
// both columns toward the same tiles
0 0 1 1 8 11111111
1 0 1 1 9 22222222
0 1 1 1 8 00000000
1 1 1 1 9 00000000
0 0 0 2 a 33333333
1 0 0 2 b 44444444
0 1 0 2 a 00000000
1 1 0 2 b 00000000
// repeated loads
0 1 1 2 1 00000000
1 1 0 1 4 00000000
0 1 0 1 0 00000000
1 1 1 1 2 00000000

//--- sim.f
mesh_pkg.sv
mesh_router.sv
mesh_tile_mem.sv
mesh_array.sv
mesh_checker.sv
tb_mesh_array.sv

//--- Bender.yml
package:
  name: mesh_array

sources:
  - mesh_pkg.sv
  - mesh_router.sv
  - mesh_tile_mem.sv
  - mesh_array.sv
  - target: test
    files:
      - mesh_checker.sv
      - tb_mesh_array.sv
